// File: Makefile
# Verilator build and run for the timer subsystem testbench

VERILATOR ?= verilator
TOP       ?= timer_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx 'SIMULATION PASSED' $(LOG) || { echo "Run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/gb_bus_pkg.sv
// I/O bus definitions for the FF00 page; one access per cycle with active-low strobes, no wait states
package gb_bus_pkg;

    // Register addresses in the I/O page
    localparam logic [15:0] ADDR_DIV  = 16'hff04;
    localparam logic [15:0] ADDR_TIMA = 16'hff05;
    localparam logic [15:0] ADDR_TMA  = 16'hff06;
    localparam logic [15:0] ADDR_TAC  = 16'hff07;
    localparam logic [15:0] ADDR_IF   = 16'hff0f;
    localparam logic [15:0] ADDR_IE   = 16'hffff;

    // Value seen on a read that no unit claims
    localparam logic [7:0] OPEN_BUS = 8'hff;

    // Number of interrupt sources held in IF
    localparam int IRQ_COUNT = 5;

    // One bus cycle as driven by the CPU side
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        re_l;
        logic        we_l;
    } io_req_t;

    // Interrupt sources; the value is also the IF/IE bit number
    // and a lower number has the higher priority
    typedef enum logic [2:0] {
        IRQ_VBLANK = 3'd0,
        IRQ_STAT   = 3'd1,
        IRQ_TIMER  = 3'd2,
        IRQ_SERIAL = 3'd3,
        IRQ_JOYPAD = 3'd4
    } irq_src_e;

endpackage

// File: rtl/interrupt_ctrl.sv
// IF and IE registers; an incoming request wins over a CPU write to IF in the same cycle
module interrupt_ctrl (
    input  logic                                I_CLOCK,
    input  logic                                I_RESET,
    input  gb_bus_pkg::io_req_t                 bus_req,
    input  logic                                timer_irq,
    input  logic [gb_bus_pkg::IRQ_COUNT-1:0]    ext_irq,
    output logic                                irq,
    output gb_bus_pkg::irq_src_e                irq_id,
    output logic [7:0]                          rd_data,
    output logic                                rd_hit
);

    logic [gb_bus_pkg::IRQ_COUNT-1:0] if_q;
    logic [7:0]                       ie_q;
    logic [gb_bus_pkg::IRQ_COUNT-1:0] req;
    logic [gb_bus_pkg::IRQ_COUNT-1:0] pending;
    logic                             sel_if;
    logic                             sel_ie;

    assign sel_if = (bus_req.addr == gb_bus_pkg::ADDR_IF);
    assign sel_ie = (bus_req.addr == gb_bus_pkg::ADDR_IE);

    // Timer overflow shares the timer slot with the external pulse
    always_comb begin
        req = ext_irq;
        req[gb_bus_pkg::IRQ_TIMER] = ext_irq[gb_bus_pkg::IRQ_TIMER] | timer_irq;
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            if_q <= '0;
        end else if (!bus_req.we_l && sel_if) begin
            if_q <= bus_req.wdata[gb_bus_pkg::IRQ_COUNT-1:0] | req;
        end else begin
            if_q <= if_q | req;
        end
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            ie_q <= 8'h00;
        end else if (!bus_req.we_l && sel_ie) begin
            ie_q <= bus_req.wdata;
        end
    end

    assign pending = if_q & ie_q[gb_bus_pkg::IRQ_COUNT-1:0];
    assign irq     = |pending;

    // Lowest bit wins, scan from the top so it is written last
    always_comb begin
        irq_id = gb_bus_pkg::IRQ_VBLANK;
        for (int i = gb_bus_pkg::IRQ_COUNT - 1; i >= 0; i--) begin
            if (pending[i]) begin
                irq_id = gb_bus_pkg::irq_src_e'(3'(i));
            end
        end
    end

    assign rd_hit  = !bus_req.re_l && (sel_if || sel_ie);
    assign rd_data = sel_if ? {3'b111, if_q} : (sel_ie ? ie_q : 8'h00);

endmodule

// File: rtl/io_read_mux.sv
// Read data merge; hits are expected to be exclusive, overlapping hits are ORed together
module io_read_mux (
    input  logic [7:0] div_rd,
    input  logic       div_hit,
    input  logic [7:0] tmr_rd,
    input  logic       tmr_hit,
    input  logic [7:0] int_rd,
    input  logic       int_hit,
    output logic [7:0] rdata
);

    logic [7:0] merged;
    logic       any_hit;

    // Mask each unit by its own hit flag
    assign merged = ({8{div_hit}} & div_rd)
                  | ({8{tmr_hit}} & tmr_rd)
                  | ({8{int_hit}} & int_rd);

    assign any_hit = div_hit || tmr_hit || int_hit;

    // Nobody answered, so the bus floats high
    assign rdata = any_hit ? merged : gb_bus_pkg::OPEN_BUS;

endmodule

// File: rtl/timer_counter.sv
// TIMA, TMA and TAC; a CPU write to TIMA beats a tick, and a TMA write in the overflow cycle is reloaded
module timer_counter (
    input  logic                I_CLOCK,
    input  logic                I_RESET,
    input  gb_bus_pkg::io_req_t bus_req,
    input  logic                tick,
    output timer_pkg::tac_t     tac,
    output logic                timer_irq,
    output logic [7:0]          rd_data,
    output logic                rd_hit
);

    logic [7:0]      tima_q;
    logic [7:0]      tma_q;
    timer_pkg::tac_t tac_q;

    logic sel_tima;
    logic sel_tma;
    logic sel_tac;
    logic tima_we;
    logic tma_we;
    logic tac_we;
    logic count_en;
    logic overflow;

    // Address decode
    assign sel_tima = (bus_req.addr == gb_bus_pkg::ADDR_TIMA);
    assign sel_tma  = (bus_req.addr == gb_bus_pkg::ADDR_TMA);
    assign sel_tac  = (bus_req.addr == gb_bus_pkg::ADDR_TAC);

    assign tima_we = !bus_req.we_l && sel_tima;
    assign tma_we  = !bus_req.we_l && sel_tma;
    assign tac_we  = !bus_req.we_l && sel_tac;

    assign count_en = tick && tac_q.enable;
    assign overflow = (tima_q == 8'hff);

    // Overflow pulse to IF, same cycle as the reload
    assign timer_irq = count_en && overflow;

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tima_q <= 8'h00;
        end else if (tima_we) begin
            tima_q <= bus_req.wdata;
        end else if (count_en) begin
            if (overflow) begin
                tima_q <= tma_we ? bus_req.wdata : tma_q;
            end else begin
                tima_q <= tima_q + 8'd1;
            end
        end
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tma_q <= 8'h00;
        end else if (tma_we) begin
            tma_q <= bus_req.wdata;
        end
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tac_q <= '0;
        end else if (tac_we) begin
            tac_q <= timer_pkg::tac_t'(bus_req.wdata[2:0]);
        end
    end

    assign tac = tac_q;

    // Read path, TAC has zeros above its three bits
    assign rd_hit = !bus_req.re_l && (sel_tima || sel_tma || sel_tac);

    always_comb begin
        if (sel_tima) begin
            rd_data = tima_q;
        end else if (sel_tma) begin
            rd_data = tma_q;
        end else if (sel_tac) begin
            rd_data = {5'b00000, tac_q};
        end else begin
            rd_data = 8'h00;
        end
    end

endmodule

// File: rtl/timer_divider.sv
// DIV register; a write of any value clears only the high byte, so the low byte keeps its phase
module timer_divider (
    input  logic                I_CLOCK,
    input  logic                I_RESET,
    input  gb_bus_pkg::io_req_t bus_req,
    output logic [7:0]          rd_data,
    output logic                rd_hit
);

    logic [timer_pkg::DIV_W-1:0] div_q;
    logic [timer_pkg::DIV_W-1:0] div_inc;
    logic                        addr_match;
    logic                        div_we;

    assign addr_match = (bus_req.addr == gb_bus_pkg::ADDR_DIV);
    assign div_we     = !bus_req.we_l && addr_match;

    // Plain increment, the carry out of the low byte steps DIV
    assign div_inc = div_q + timer_pkg::DIV_W'(1);

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            div_q <= '0;
        end else if (div_we) begin
            // Low byte still advances on a write
            div_q <= {8'h00, div_inc[7:0]};
        end else begin
            div_q <= div_inc;
        end
    end

    assign rd_hit  = !bus_req.re_l && addr_match;
    assign rd_data = div_q[timer_pkg::DIV_W-1 -: 8];

endmodule

// File: rtl/timer_pkg.sv
// Timer definitions; all rates are counted in I_CLOCK cycles, with no assumption on the clock frequency
package timer_pkg;

    // Width of the gated prescaler that feeds TIMA
    localparam int PRESCALE_W = 11;

    // Width of the free-running divider, high byte is DIV
    localparam int DIV_W = 16;

    // TAC rate field, named by the tap period in cycles
    typedef enum logic [1:0] {
        RATE_2048 = 2'd0,
        RATE_32   = 2'd1,
        RATE_128  = 2'd2,
        RATE_512  = 2'd3
    } tac_rate_e;

    // TAC register layout, enable sits in bit 2
    typedef struct packed {
        logic      enable;
        tac_rate_e rate;
    } tac_t;

    // Edge detector state for the selected prescaler tap
    typedef enum logic {
        TICK_ARMED = 1'b0,
        TICK_FIRED = 1'b1
    } tick_state_e;

endpackage

// File: rtl/timer_prescaler.sv
// TIMA tick source; the prescaler only runs while TAC is enabled, but the tap edge is tracked always
module timer_prescaler (
    input  logic            I_CLOCK,
    input  logic            I_RESET,
    input  timer_pkg::tac_t tac,
    output logic            tick
);

    logic [timer_pkg::PRESCALE_W-1:0] prescale_q;
    logic                             tap;
    timer_pkg::tick_state_e           state_q;
    timer_pkg::tick_state_e           state_d;

    // Gated prescaler
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            prescale_q <= '0;
        end else if (tac.enable) begin
            prescale_q <= prescale_q + timer_pkg::PRESCALE_W'(1);
        end
    end

    // One full tap period per TIMA step
    always_comb begin
        case (tac.rate)
            timer_pkg::RATE_2048: tap = prescale_q[10];
            timer_pkg::RATE_32:   tap = prescale_q[4];
            timer_pkg::RATE_128:  tap = prescale_q[6];
            timer_pkg::RATE_512:  tap = prescale_q[8];
            default:              tap = 1'b0;
        endcase
    end

    // One tick per high level of the tap
    always_comb begin
        state_d = state_q;
        tick    = 1'b0;
        case (state_q)
            timer_pkg::TICK_ARMED: begin
                if (tap) begin
                    state_d = timer_pkg::TICK_FIRED;
                    tick    = 1'b1;
                end
            end
            timer_pkg::TICK_FIRED: begin
                // Wait for the tap to drop before arming again
                if (!tap) begin
                    state_d = timer_pkg::TICK_ARMED;
                end
            end
            default: begin
                state_d = timer_pkg::TICK_ARMED;
            end
        endcase
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            state_q <= timer_pkg::TICK_ARMED;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: rtl/timer_subsystem.sv
// Timer and interrupt block top; read data is combinational from bus_req in the same cycle
module timer_subsystem (
    input  logic                                I_CLOCK,
    input  logic                                I_RESET,
    input  gb_bus_pkg::io_req_t                 bus_req,
    input  logic [gb_bus_pkg::IRQ_COUNT-1:0]    ext_irq,
    output logic [7:0]                          rdata,
    output logic                                irq,
    output gb_bus_pkg::irq_src_e                irq_id
);

    timer_pkg::tac_t tac;
    logic            tick;
    logic            timer_irq;

    logic [7:0] div_rd;
    logic       div_hit;
    logic [7:0] tmr_rd;
    logic       tmr_hit;
    logic [7:0] int_rd;
    logic       int_hit;

    timer_divider u_divider (
        .I_CLOCK (I_CLOCK),
        .I_RESET (I_RESET),
        .bus_req (bus_req),
        .rd_data (div_rd),
        .rd_hit  (div_hit)
    );

    timer_prescaler u_prescaler (
        .I_CLOCK (I_CLOCK),
        .I_RESET (I_RESET),
        .tac     (tac),
        .tick    (tick)
    );

    timer_counter u_counter (
        .I_CLOCK   (I_CLOCK),
        .I_RESET   (I_RESET),
        .bus_req   (bus_req),
        .tick      (tick),
        .tac       (tac),
        .timer_irq (timer_irq),
        .rd_data   (tmr_rd),
        .rd_hit    (tmr_hit)
    );

    interrupt_ctrl u_int_ctrl (
        .I_CLOCK   (I_CLOCK),
        .I_RESET   (I_RESET),
        .bus_req   (bus_req),
        .timer_irq (timer_irq),
        .ext_irq   (ext_irq),
        .irq       (irq),
        .irq_id    (irq_id),
        .rd_data   (int_rd),
        .rd_hit    (int_hit)
    );

    io_read_mux u_read_mux (
        .div_rd  (div_rd),
        .div_hit (div_hit),
        .tmr_rd  (tmr_rd),
        .tmr_hit (tmr_hit),
        .int_rd  (int_rd),
        .int_hit (int_hit),
        .rdata   (rdata)
    );

endmodule

// File: sim/timer_tb.sv
// Testbench for timer_subsystem; each cycle is checked against a model, and the run stops at 40000 cycles
module timer_tb;

    localparam int CYCLE_LIMIT = 40000;
    localparam int SYNC_LIMIT  = 4096;

    // Model of every register the DUT holds
    typedef struct packed {
        logic [timer_pkg::DIV_W-1:0]      div;
        logic [timer_pkg::PRESCALE_W-1:0] pre;
        timer_pkg::tick_state_e           state;
        logic [7:0]                       tima;
        logic [7:0]                       tma;
        timer_pkg::tac_t                  tac;
        logic [gb_bus_pkg::IRQ_COUNT-1:0] iflag;
        logic [7:0]                       ie;
    } model_t;

    typedef struct packed {
        logic [7:0]           rdata;
        logic                 irq;
        gb_bus_pkg::irq_src_e irq_id;
    } expect_t;

    logic                             I_CLOCK;
    logic                             I_RESET;
    gb_bus_pkg::io_req_t              bus_req;
    logic [gb_bus_pkg::IRQ_COUNT-1:0] ext_irq;
    logic [7:0]                       rdata;
    logic                             irq;
    gb_bus_pkg::irq_src_e             irq_id;

    model_t      model;
    expect_t     exp_now;
    int unsigned seed_val;
    int          cycle_count = 0;
    int          rdata_errs = 0;
    int          irq_errs = 0;
    int          id_errs = 0;
    int          read_errs = 0;
    int          other_errs = 0;

    // Tap period in cycles, indexed by the TAC rate code
    int periods [4] = '{2048, 32, 128, 512};

    timer_subsystem uut (
        .I_CLOCK (I_CLOCK),
        .I_RESET (I_RESET),
        .bus_req (bus_req),
        .ext_irq (ext_irq),
        .rdata   (rdata),
        .irq     (irq),
        .irq_id  (irq_id)
    );

    initial begin
        I_CLOCK = 1'b0;
        forever #20 I_CLOCK = ~I_CLOCK;
    end

    function automatic gb_bus_pkg::io_req_t build_req(logic [15:0] addr, logic [7:0] data,
                                                      logic rd, logic wr);
        gb_bus_pkg::io_req_t r;
        r.addr  = addr;
        r.wdata = data;
        r.re_l  = !rd;
        r.we_l  = !wr;
        return r;
    endfunction

    // A tap with a period of P cycles is the prescaler bit of weight P/2
    function automatic logic model_tap(model_t m);
        logic [timer_pkg::PRESCALE_W-1:0] weight;
        weight = 11'(periods[m.tac.rate] / 2);
        return |(m.pre & weight);
    endfunction

    function automatic logic model_tick(model_t m);
        return model_tap(m) && (m.state == timer_pkg::TICK_ARMED);
    endfunction

    // Next state of the model after one rising edge with this request
    function automatic model_t step_model(model_t m, gb_bus_pkg::io_req_t req,
                                          logic [gb_bus_pkg::IRQ_COUNT-1:0] ext);
        model_t                           n;
        logic                             wr;
        logic                             count;
        logic                             ovf;
        logic [timer_pkg::DIV_W-1:0]      div_next;
        logic [gb_bus_pkg::IRQ_COUNT-1:0] reqs;
        n        = m;
        wr       = !req.we_l;
        count    = model_tick(m) && m.tac.enable;
        ovf      = count && (m.tima == 8'hff);
        div_next = m.div + 16'd1;
        // Only the high byte clears on a DIV write
        n.div = (wr && req.addr == gb_bus_pkg::ADDR_DIV) ? {8'h00, div_next[7:0]} : div_next;
        if (m.tac.enable) begin
            n.pre = m.pre + 11'd1;
        end
        if (model_tick(m)) begin
            n.state = timer_pkg::TICK_FIRED;
        end else if (!model_tap(m)) begin
            n.state = timer_pkg::TICK_ARMED;
        end
        if (wr && req.addr == gb_bus_pkg::ADDR_TIMA) begin
            n.tima = req.wdata;
        end else if (ovf) begin
            n.tima = (wr && req.addr == gb_bus_pkg::ADDR_TMA) ? req.wdata : m.tma;
        end else if (count) begin
            n.tima = m.tima + 8'd1;
        end
        if (wr && req.addr == gb_bus_pkg::ADDR_TMA) begin
            n.tma = req.wdata;
        end
        if (wr && req.addr == gb_bus_pkg::ADDR_TAC) begin
            n.tac = timer_pkg::tac_t'(req.wdata[2:0]);
        end
        reqs = ext;
        reqs[gb_bus_pkg::IRQ_TIMER] = ext[gb_bus_pkg::IRQ_TIMER] | ovf;
        // New requests are ORed in after a CPU write to IF
        if (wr && req.addr == gb_bus_pkg::ADDR_IF) begin
            n.iflag = req.wdata[gb_bus_pkg::IRQ_COUNT-1:0] | reqs;
        end else begin
            n.iflag = m.iflag | reqs;
        end
        if (wr && req.addr == gb_bus_pkg::ADDR_IE) begin
            n.ie = req.wdata;
        end
        return n;
    endfunction

    // Outputs the DUT should show for this state and request
    function automatic expect_t expect_outputs(model_t m, gb_bus_pkg::io_req_t req);
        expect_t                          e;
        logic [gb_bus_pkg::IRQ_COUNT-1:0] pending;
        logic                             found;
        e.rdata = gb_bus_pkg::OPEN_BUS;
        if (!req.re_l) begin
            case (req.addr)
                gb_bus_pkg::ADDR_DIV:  e.rdata = m.div[15:8];
                gb_bus_pkg::ADDR_TIMA: e.rdata = m.tima;
                gb_bus_pkg::ADDR_TMA:  e.rdata = m.tma;
                gb_bus_pkg::ADDR_TAC:  e.rdata = {5'b00000, m.tac};
                gb_bus_pkg::ADDR_IF:   e.rdata = {3'b111, m.iflag};
                gb_bus_pkg::ADDR_IE:   e.rdata = m.ie;
                default:               e.rdata = gb_bus_pkg::OPEN_BUS;
            endcase
        end
        pending  = m.iflag & m.ie[gb_bus_pkg::IRQ_COUNT-1:0];
        e.irq    = |pending;
        e.irq_id = gb_bus_pkg::IRQ_VBLANK;
        found    = 1'b0;
        for (int i = 0; i < gb_bus_pkg::IRQ_COUNT; i++) begin
            if (pending[i] && !found) begin
                e.irq_id = gb_bus_pkg::irq_src_e'(3'(i));
                found    = 1'b1;
            end
        end
        return e;
    endfunction

    function automatic logic tick_ahead(model_t m, logic need_ovf);
        return model_tick(m) && m.tac.enable && (!need_ovf || m.tima == 8'hff);
    endfunction

    function automatic int total_errors();
        return rdata_errs + irq_errs + id_errs + read_errs + other_errs;
    endfunction

    task automatic drive_cycle(input gb_bus_pkg::io_req_t req,
                               input logic [gb_bus_pkg::IRQ_COUNT-1:0] irqs);
        @(posedge I_CLOCK);
        bus_req <= req;
        ext_irq <= irqs;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        drive_cycle(build_req(addr, data, 1'b0, 1'b1), '0);
    endtask

    task automatic read_for(input logic [15:0] addr, input int n);
        repeat (n) drive_cycle(build_req(addr, 8'h00, 1'b1, 1'b0), '0);
    endtask

    // Directed read against a fixed value
    task automatic check_read(input logic [15:0] addr, input logic [7:0] expected);
        drive_cycle(build_req(addr, 8'h00, 1'b1, 1'b0), '0);
        @(negedge I_CLOCK);
        assert (rdata === expected) else begin
            read_errs++;
            $display("CHECK FAILED at time %0t: rdata of %04h expected %02h actual %02h",
                     $time, addr, expected, rdata);
        end
    endtask

    // Returns just before the posedge that opens a tick cycle
    task automatic sync_to_tick(input logic need_ovf);
        int waited;
        waited = 0;
        @(negedge I_CLOCK);
        while (!tick_ahead(step_model(model, bus_req, ext_irq), need_ovf)
               && waited < SYNC_LIMIT) begin
            drive_cycle(build_req(gb_bus_pkg::ADDR_TIMA, 8'h00, 1'b1, 1'b0), '0);
            @(negedge I_CLOCK);
            waited++;
        end
        if (waited >= SYNC_LIMIT) begin
            other_errs++;
            $display("Timer tick did not arrive within %0d cycles at time %0t", SYNC_LIMIT, $time);
        end
    endtask

    task automatic random_traffic(input int n);
        gb_bus_pkg::io_req_t              req;
        logic [gb_bus_pkg::IRQ_COUNT-1:0] irqs;
        int                               pick;
        repeat (n) begin
            pick = $urandom_range(0, 6);
            case (pick)
                0:       req.addr = gb_bus_pkg::ADDR_DIV;
                1:       req.addr = gb_bus_pkg::ADDR_TIMA;
                2:       req.addr = gb_bus_pkg::ADDR_TMA;
                3:       req.addr = gb_bus_pkg::ADDR_TAC;
                4:       req.addr = gb_bus_pkg::ADDR_IF;
                5:       req.addr = gb_bus_pkg::ADDR_IE;
                default: req.addr = 16'($urandom);
            endcase
            req.wdata = 8'($urandom);
            req.re_l  = 1'($urandom);
            req.we_l  = ($urandom_range(0, 3) != 0);
            irqs      = ($urandom_range(0, 7) == 0) ? 5'($urandom) : 5'b00000;
            drive_cycle(req, irqs);
        end
    endtask

    task automatic report_counts();
        $display("Errors: rdata %0d, irq %0d, irq_id %0d, directed %0d, other %0d, total %0d",
                 rdata_errs, irq_errs, id_errs, read_errs, other_errs, total_errors());
    endtask

    always @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            model <= '0;
        end else begin
            model <= step_model(model, bus_req, ext_irq);
        end
    end

    // Compare on the falling edge, when all outputs have settled
    always @(negedge I_CLOCK) begin
        if (!I_RESET) begin
            exp_now = expect_outputs(model, bus_req);
            assert (rdata === exp_now.rdata) else begin
                rdata_errs++;
                $display("CHECK FAILED at time %0t: rdata expected %02h actual %02h",
                         $time, exp_now.rdata, rdata);
            end
            assert (irq === exp_now.irq) else begin
                irq_errs++;
                $display("CHECK FAILED at time %0t: irq expected %0b actual %0b",
                         $time, exp_now.irq, irq);
            end
            assert (irq_id === exp_now.irq_id) else begin
                id_errs++;
                $display("CHECK FAILED at time %0t: irq_id expected %0d actual %0d",
                         $time, exp_now.irq_id, irq_id);
            end
        end
    end

    always @(posedge I_CLOCK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            report_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        seed_val = $urandom(32'h3aeb_3d6b);
        I_RESET  = 1'b1;
        bus_req  = build_req(16'h0000, 8'h00, 1'b0, 1'b0);
        ext_irq  = '0;
        repeat (16) @(posedge I_CLOCK);
        I_RESET <= 1'b0;

        check_read(gb_bus_pkg::ADDR_DIV, 8'h00);
        check_read(gb_bus_pkg::ADDR_TIMA, 8'h00);
        check_read(gb_bus_pkg::ADDR_TMA, 8'h00);
        check_read(gb_bus_pkg::ADDR_TAC, 8'h00);
        check_read(gb_bus_pkg::ADDR_IE, 8'h00);
        check_read(gb_bus_pkg::ADDR_IF, 8'he0);
        check_read(16'hff10, 8'hff);
        check_read(16'h0000, 8'hff);

        // DIV steps around a clear in mid phase
        read_for(gb_bus_pkg::ADDR_DIV, 600);
        write_reg(gb_bus_pkg::ADDR_DIV, 8'($urandom));
        read_for(gb_bus_pkg::ADDR_DIV, 600);

        for (int r = 0; r < 4; r++) begin
            write_reg(gb_bus_pkg::ADDR_TAC, {5'b00000, 1'b1, 2'(r)});
            write_reg(gb_bus_pkg::ADDR_TIMA, 8'h00);
            read_for(gb_bus_pkg::ADDR_TIMA, periods[r] * 3 + 16);
        end
        write_reg(gb_bus_pkg::ADDR_TAC, 8'h01);
        read_for(gb_bus_pkg::ADDR_TIMA, 1000);

        // Overflow, reload, and writes that collide with a tick
        write_reg(gb_bus_pkg::ADDR_TMA, 8'hf0);
        write_reg(gb_bus_pkg::ADDR_TIMA, 8'hfc);
        write_reg(gb_bus_pkg::ADDR_TAC, 8'h05);
        read_for(gb_bus_pkg::ADDR_TIMA, 700);
        sync_to_tick(1'b1);
        write_reg(gb_bus_pkg::ADDR_TMA, 8'h80);
        read_for(gb_bus_pkg::ADDR_TIMA, 40);
        sync_to_tick(1'b0);
        write_reg(gb_bus_pkg::ADDR_TIMA, 8'h33);
        read_for(gb_bus_pkg::ADDR_TIMA, 40);

        // Timer interrupt through IF and IE
        write_reg(gb_bus_pkg::ADDR_TMA, 8'hfc);
        write_reg(gb_bus_pkg::ADDR_TIMA, 8'hfc);
        write_reg(gb_bus_pkg::ADDR_IE, 8'h04);
        sync_to_tick(1'b1);
        read_for(gb_bus_pkg::ADDR_IF, 8);
        write_reg(gb_bus_pkg::ADDR_IF, 8'h00);
        read_for(gb_bus_pkg::ADDR_IF, 4);
        sync_to_tick(1'b1);
        write_reg(gb_bus_pkg::ADDR_IF, 8'h00);
        read_for(gb_bus_pkg::ADDR_IF, 4);
        write_reg(gb_bus_pkg::ADDR_IF, 8'h00);
        write_reg(gb_bus_pkg::ADDR_IE, 8'h00);
        sync_to_tick(1'b1);
        read_for(gb_bus_pkg::ADDR_IF, 8);

        write_reg(gb_bus_pkg::ADDR_TMA, 8'hf8);
        random_traffic(6000);

        report_counts();
        if (total_errors() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
rtl/gb_bus_pkg.sv
rtl/timer_pkg.sv
rtl/timer_divider.sv
rtl/timer_prescaler.sv
rtl/timer_counter.sv
rtl/interrupt_ctrl.sv
rtl/io_read_mux.sv
rtl/timer_subsystem.sv
sim/timer_tb.sv
